// ==== hdl/boot_pkg.sv ====
package boot_pkg;

  // word and address widths
  localparam int data_width_c = 32;
  localparam int addr_width_c = 16;

  // register 0 is freeze, bit 0 holds the freeze flag
  localparam int num_cfg_regs_c = 8;

  typedef logic [data_width_c-1:0] data_t;
  typedef logic [addr_width_c-1:0] addr_t;
  typedef logic [2:0]              cfg_idx_t;

  // values for config registers 1 to 7, index matches register number
  localparam data_t [1:num_cfg_regs_c-1] cfg_table_c = '{
    32'h0000_0001,
    32'h0000_0010,
    32'h8000_0000,
    32'h0000_0400,
    32'hdead_0005,
    32'h0001_0000,
    32'hc0de_0007
  };

  // command to memory, top address bit selects config space
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t data;
  } mem_cmd_t;

  // response from memory
  typedef struct packed {
    logic  wr;
    data_t data;
  } mem_resp_t;

endpackage

// ==== hdl/cfg_loader.sv ====
`timescale 1ns/1ps

module cfg_loader
  (input                         clk_i
   , input                       rst_n_i

   , output boot_pkg::mem_cmd_t  cmd_o
   , output logic                cmd_v_o
   , input                       cmd_ready_i

   , input                       resp_v_i

   , output logic                done_o
   );

  // walks 1..7 then wraps to 0, the freeze register
  boot_pkg::cfg_idx_t idx_r;
  logic               busy_r;
  logic               done_r;
  boot_pkg::data_t    cmd_data;

  always_comb
  begin
    cmd_data = '0;
    // freeze register gets 0 to release the core
    if (idx_r != '0)
    begin
      cmd_data = boot_pkg::cfg_table_c[idx_r];
    end
  end

  assign cmd_o.wr   = 1'b1;
  assign cmd_o.addr = {1'b1,
                       {(boot_pkg::addr_width_c-1-$bits(boot_pkg::cfg_idx_t)){1'b0}},
                       idx_r};
  assign cmd_o.data = cmd_data;

  // one write in flight at a time
  assign cmd_v_o = ~busy_r & ~done_r;
  assign done_o  = done_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      idx_r  <= boot_pkg::cfg_idx_t'(1);
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (busy_r)
    begin
      if (resp_v_i)
      begin
        busy_r <= 1'b0;
        idx_r  <= idx_r + 1'b1;
        // ack of the freeze clear ends the sequence
        if (idx_r == '0)
        begin
          done_r <= 1'b1;
        end
      end
    end
    else if (cmd_v_o && cmd_ready_i)
    begin
      busy_r <= 1'b1;
    end
  end

endmodule

// ==== hdl/nbf_loader.sv ====
`timescale 1ns/1ps

module nbf_loader
  (input                         clk_i
   , input                       rst_n_i

   , input                       start_i

   , input                       nbf_v_i
   , input  boot_pkg::data_t     nbf_data_i
   , input                       nbf_last_i
   , output logic                nbf_ready_o

   , output boot_pkg::mem_cmd_t  cmd_o
   , output logic                cmd_v_o
   , input                       cmd_ready_i

   , input                       resp_v_i

   , output logic                done_o
   );

  // write pointer into program space
  logic [boot_pkg::addr_width_c-2:0] wptr_r;
  boot_pkg::data_t                   data_r;
  logic                              cmd_v_r;
  logic                              wait_r;
  logic                              last_r;
  logic                              done_r;

  // take a new word only when nothing is outstanding
  assign nbf_ready_o = start_i & ~done_r & ~cmd_v_r & ~wait_r;

  assign cmd_o.wr   = 1'b1;
  assign cmd_o.addr = {1'b0, wptr_r};
  assign cmd_o.data = data_r;
  assign cmd_v_o    = cmd_v_r;
  assign done_o     = done_r;

  always_ff @(posedge clk_i)
  begin
    if (nbf_v_i && nbf_ready_o)
    begin
      data_r <= nbf_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r  <= '0;
      cmd_v_r <= 1'b0;
      wait_r  <= 1'b0;
      last_r  <= 1'b0;
      done_r  <= 1'b0;
    end
    else if (nbf_v_i && nbf_ready_o)
    begin
      cmd_v_r <= 1'b1;
      last_r  <= nbf_last_i;
    end
    else if (cmd_v_r && cmd_ready_i)
    begin
      cmd_v_r <= 1'b0;
      wait_r  <= 1'b1;
    end
    else if (wait_r && resp_v_i)
    begin
      wait_r <= 1'b0;
      wptr_r <= wptr_r + 1'b1;
      done_r <= last_r;
    end
  end

endmodule

// ==== hdl/load_arbiter.sv ====
`timescale 1ns/1ps

module load_arbiter
  (input                          cfg_done_i
   , input                        nbf_done_i

   , input  boot_pkg::mem_cmd_t   cfg_cmd_i
   , input                        cfg_cmd_v_i
   , output logic                 cfg_cmd_ready_o
   , output logic                 cfg_resp_v_o

   , input  boot_pkg::mem_cmd_t   nbf_cmd_i
   , input                        nbf_cmd_v_i
   , output logic                 nbf_cmd_ready_o
   , output logic                 nbf_resp_v_o

   , input                        host_cmd_v_i
   , input  boot_pkg::addr_t      host_addr_i
   , output logic                 host_cmd_ready_o
   , output logic                 host_resp_v_o
   , output boot_pkg::data_t      host_data_o
   , input                        host_resp_ready_i

   , output boot_pkg::mem_cmd_t   mem_cmd_o
   , output logic                 mem_cmd_v_o
   , input                        mem_cmd_ready_i
   , input  boot_pkg::mem_resp_t  mem_resp_i
   , input                        mem_resp_v_i
   , output logic                 mem_resp_ready_o
   );

  logic cfg_phase;
  logic nbf_phase;
  logic host_phase;
  boot_pkg::mem_cmd_t host_cmd;

  // phases are mutually exclusive, so routing is fixed
  assign cfg_phase  = ~cfg_done_i;
  assign nbf_phase  = cfg_done_i & ~nbf_done_i;
  assign host_phase = cfg_done_i & nbf_done_i;

  // host only reads
  assign host_cmd.wr   = 1'b0;
  assign host_cmd.addr = host_addr_i;
  assign host_cmd.data = '0;

  assign mem_cmd_o   = cfg_phase ? cfg_cmd_i : (nbf_phase ? nbf_cmd_i : host_cmd);
  assign mem_cmd_v_o = (cfg_phase & cfg_cmd_v_i) | (nbf_phase & nbf_cmd_v_i)
                       | (host_phase & host_cmd_v_i);

  assign cfg_cmd_ready_o  = cfg_phase & mem_cmd_ready_i;
  assign nbf_cmd_ready_o  = nbf_phase & mem_cmd_ready_i;
  assign host_cmd_ready_o = host_phase & mem_cmd_ready_i;

  // loader acks are write acks and are taken at once
  assign cfg_resp_v_o = cfg_phase & mem_resp_v_i & mem_resp_i.wr;
  assign nbf_resp_v_o = nbf_phase & mem_resp_v_i & mem_resp_i.wr;

  assign host_resp_v_o    = host_phase & mem_resp_v_i;
  assign host_data_o      = host_phase ? mem_resp_i.data : '0;
  assign mem_resp_ready_o = ~host_phase | host_resp_ready_i;

endmodule

// ==== hdl/boot_mem.sv ====
`timescale 1ns/1ps

module boot_mem
  #(parameter int mem_words_p = 64)
  (input                          clk_i
   , input                        rst_n_i

   , input  boot_pkg::mem_cmd_t   cmd_i
   , input                        cmd_v_i
   , output logic                 cmd_ready_o

   , output boot_pkg::mem_resp_t  resp_o
   , output logic                 resp_v_o
   , input                        resp_ready_i

   , output logic                 freeze_o
   );

  localparam int word_idx_width_lp = $clog2(mem_words_p);

  boot_pkg::data_t mem_r [mem_words_p];
  boot_pkg::data_t cfg_r [boot_pkg::num_cfg_regs_c];

  logic                         cfg_sel;
  logic [word_idx_width_lp-1:0] word_idx;
  boot_pkg::cfg_idx_t           cfg_idx;
  boot_pkg::data_t              rd_data;
  logic                         accept;

  logic                resp_v_r;
  boot_pkg::mem_resp_t resp_r;

  // top address bit picks config space, low bits wrap the memory
  assign cfg_sel  = cmd_i.addr[boot_pkg::addr_width_c-1];
  assign word_idx = cmd_i.addr[word_idx_width_lp-1:0];
  assign cfg_idx  = cmd_i.addr[$bits(boot_pkg::cfg_idx_t)-1:0];
  assign rd_data  = cfg_sel ? cfg_r[cfg_idx] : mem_r[word_idx];

  // no new command while a response waits
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = cfg_r[0][0];

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.wr   <= cmd_i.wr;
      // writes echo their data, reads return the old word
      resp_r.data <= cmd_i.wr ? cmd_i.data : rd_data;
      if (cmd_i.wr && !cfg_sel)
      begin
        mem_r[word_idx] <= cmd_i.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < boot_pkg::num_cfg_regs_c; i++)
      begin
        cfg_r[i] <= '0;
      end
      // core comes up frozen
      cfg_r[0] <= boot_pkg::data_t'(1);
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (accept && cmd_i.wr && cfg_sel)
      begin
        cfg_r[cfg_idx] <= cmd_i.data;
      end
      if (accept)
      begin
        resp_v_r <= 1'b1;
      end
      else if (resp_ready_i)
      begin
        resp_v_r <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/boot_loader.sv ====
`timescale 1ns/1ps

module boot_loader
  #(parameter int mem_words_p = 64)
  (input                       clk_i
   , input                     rst_n_i

   , input                     nbf_v_i
   , input  boot_pkg::data_t   nbf_data_i
   , input                     nbf_last_i
   , output logic              nbf_ready_o

   , input                     host_cmd_v_i
   , input  boot_pkg::addr_t   host_addr_i
   , output logic              host_cmd_ready_o

   , output logic              host_resp_v_o
   , output boot_pkg::data_t   host_data_o
   , input                     host_resp_ready_i

   , output logic              freeze_o
   , output logic              boot_done_o
   );

  boot_pkg::mem_cmd_t  cfg_cmd;
  logic                cfg_cmd_v;
  logic                cfg_cmd_ready;
  logic                cfg_resp_v;
  logic                cfg_done;

  boot_pkg::mem_cmd_t  nbf_cmd;
  logic                nbf_cmd_v;
  logic                nbf_cmd_ready;
  logic                nbf_resp_v;
  logic                nbf_done;

  boot_pkg::mem_cmd_t  mem_cmd;
  logic                mem_cmd_v;
  logic                mem_cmd_ready;
  boot_pkg::mem_resp_t mem_resp;
  logic                mem_resp_v;
  logic                mem_resp_ready;

  assign boot_done_o = nbf_done;

  cfg_loader i_cfg_loader
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_o(cfg_cmd)
     ,.cmd_v_o(cfg_cmd_v)
     ,.cmd_ready_i(cfg_cmd_ready)
     ,.resp_v_i(cfg_resp_v)
     ,.done_o(cfg_done)
     );

  // program load waits for config to finish
  nbf_loader i_nbf_loader
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.start_i(cfg_done)
     ,.nbf_v_i(nbf_v_i)
     ,.nbf_data_i(nbf_data_i)
     ,.nbf_last_i(nbf_last_i)
     ,.nbf_ready_o(nbf_ready_o)
     ,.cmd_o(nbf_cmd)
     ,.cmd_v_o(nbf_cmd_v)
     ,.cmd_ready_i(nbf_cmd_ready)
     ,.resp_v_i(nbf_resp_v)
     ,.done_o(nbf_done)
     );

  load_arbiter i_load_arbiter
    (.cfg_done_i(cfg_done)
     ,.nbf_done_i(nbf_done)
     ,.cfg_cmd_i(cfg_cmd)
     ,.cfg_cmd_v_i(cfg_cmd_v)
     ,.cfg_cmd_ready_o(cfg_cmd_ready)
     ,.cfg_resp_v_o(cfg_resp_v)
     ,.nbf_cmd_i(nbf_cmd)
     ,.nbf_cmd_v_i(nbf_cmd_v)
     ,.nbf_cmd_ready_o(nbf_cmd_ready)
     ,.nbf_resp_v_o(nbf_resp_v)
     ,.host_cmd_v_i(host_cmd_v_i)
     ,.host_addr_i(host_addr_i)
     ,.host_cmd_ready_o(host_cmd_ready_o)
     ,.host_resp_v_o(host_resp_v_o)
     ,.host_data_o(host_data_o)
     ,.host_resp_ready_i(host_resp_ready_i)
     ,.mem_cmd_o(mem_cmd)
     ,.mem_cmd_v_o(mem_cmd_v)
     ,.mem_cmd_ready_i(mem_cmd_ready)
     ,.mem_resp_i(mem_resp)
     ,.mem_resp_v_i(mem_resp_v)
     ,.mem_resp_ready_o(mem_resp_ready)
     );

  boot_mem #(.mem_words_p(mem_words_p)) i_boot_mem
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_i(mem_cmd)
     ,.cmd_v_i(mem_cmd_v)
     ,.cmd_ready_o(mem_cmd_ready)
     ,.resp_o(mem_resp)
     ,.resp_v_o(mem_resp_v)
     ,.resp_ready_i(mem_resp_ready)
     ,.freeze_o(freeze_o)
     );

endmodule

// ==== test/boot_loader_checker.sv ====
`timescale 1ns/1ps

module boot_loader_checker
  (input                      clk_i
   , input                    rst_n_i
   , input                    freeze_i
   , input                    nbf_ready_i
   , input                    boot_done_i
   , input                    host_cmd_ready_i
   , input                    host_resp_v_i
   , input  boot_pkg::data_t  host_data_i
   , input                    host_resp_ready_i
   );

  // assertion failures so far
  int fail_cnt = 0;

  // program stream stays closed while the core is frozen
  no_load_while_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(freeze_i && nbf_ready_i))
    else
    begin
      $error("nbf_ready_o is high while freeze_o is high");
      fail_cnt++;
    end

  boot_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      boot_done_i |=> boot_done_i)
    else
    begin
      $error("boot_done_o fell after it had risen");
      fail_cnt++;
    end

  // a stalled response keeps its valid and data
  resp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (host_resp_v_i && !host_resp_ready_i) |=> (host_resp_v_i && $stable(host_data_i)))
    else
    begin
      $error("host response changed while host_resp_ready_i was low");
      fail_cnt++;
    end

  host_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !boot_done_i |-> !host_cmd_ready_i)
    else
    begin
      $error("host_cmd_ready_o is high before boot_done_o");
      fail_cnt++;
    end

endmodule

bind boot_loader boot_loader_checker i_boot_loader_checker
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.freeze_i(freeze_o)
   ,.nbf_ready_i(nbf_ready_o)
   ,.boot_done_i(boot_done_o)
   ,.host_cmd_ready_i(host_cmd_ready_o)
   ,.host_resp_v_i(host_resp_v_o)
   ,.host_data_i(host_data_o)
   ,.host_resp_ready_i(host_resp_ready_i)
   );

// ==== test/tb_boot_loader.sv ====
`timescale 1ns/1ps

module tb_boot_loader;

  localparam int num_words_c = 20;
  // rough cycle budget per test
  localparam int reset_len_c    = 4;
  localparam int gate_len_c     = 10;
  localparam int cfg_len_c      = 32;
  localparam int load_len_c     = num_words_c * 7;
  localparam int readback_len_c = (num_words_c + 8) * 4;
  localparam int bp_len_c       = num_words_c * 12;
  localparam int cycle_limit_c  = 2 * (reset_len_c + gate_len_c + cfg_len_c + load_len_c
                                       + readback_len_c + bp_len_c);

  logic            clk = 1'b0;
  logic            rst_n;
  logic            nbf_v;
  boot_pkg::data_t nbf_data;
  logic            nbf_last;
  logic            nbf_ready;
  logic            host_cmd_v;
  boot_pkg::addr_t host_addr;
  logic            host_cmd_ready;
  logic            host_resp_v;
  boot_pkg::data_t host_data;
  logic            host_resp_ready;
  logic            freeze;
  logic            boot_done;

  integer          seed = 32'ha1960fc8;
  int              cycles = 0;
  int              checks = 0;
  int              errors = 0;
  int              test_start = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  boot_pkg::data_t words[$];

  boot_loader #(.mem_words_p(64)) i_boot_loader
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.nbf_v_i(nbf_v)
     ,.nbf_data_i(nbf_data)
     ,.nbf_last_i(nbf_last)
     ,.nbf_ready_o(nbf_ready)
     ,.host_cmd_v_i(host_cmd_v)
     ,.host_addr_i(host_addr)
     ,.host_cmd_ready_o(host_cmd_ready)
     ,.host_resp_v_o(host_resp_v)
     ,.host_data_o(host_data)
     ,.host_resp_ready_i(host_resp_ready)
     ,.freeze_o(freeze)
     ,.boot_done_o(boot_done)
     );

  always #2 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit_c)
    begin
      $display("timeout after %0d cycles, a DUT handshake never completed", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic int fail_total();
    return errors + i_boot_loader.i_boot_loader_checker.fail_cnt;
  endfunction

  task automatic check_value(input string name, input boot_pkg::data_t expected,
                             input boot_pkg::data_t actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    if (fail_total() == test_start)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d error(s)", name, fail_total() - test_start);
    end
    test_start = fail_total();
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #1;
  endtask

  task automatic send_word(input boot_pkg::data_t data, input logic last);
    nbf_v    = 1'b1;
    nbf_data = data;
    nbf_last = last;
    @(negedge clk);
    while (!nbf_ready)
    begin
      @(negedge clk);
    end
    next_drive();
    nbf_v    = 1'b0;
    nbf_last = 1'b0;
  endtask

  // stall is the number of extra cycles the response is held off
  task automatic host_read(input boot_pkg::addr_t addr, input int stall,
                           output boot_pkg::data_t data);
    host_resp_ready = (stall == 0);
    host_cmd_v      = 1'b1;
    host_addr       = addr;
    @(negedge clk);
    while (!host_cmd_ready)
    begin
      @(negedge clk);
    end
    next_drive();
    host_cmd_v = 1'b0;
    @(negedge clk);
    while (!host_resp_v)
    begin
      @(negedge clk);
    end
    if (stall > 0)
    begin
      repeat (stall) next_drive();
      host_resp_ready = 1'b1;
      @(negedge clk);
      check_bit("host_resp_v_o", 1'b1, host_resp_v);
    end
    data = host_data;
    next_drive();
  endtask

  initial
  begin
    int              gap;
    int              stall;
    int              wait_cnt;
    boot_pkg::data_t word;
    boot_pkg::data_t rd;
    boot_pkg::cfg_idx_t ri;

    rst_n           = 1'b0;
    nbf_v           = 1'b0;
    nbf_data        = '0;
    nbf_last        = 1'b0;
    host_cmd_v      = 1'b0;
    host_addr       = '0;
    host_resp_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_bit("freeze_o", 1'b1, freeze);
    check_bit("boot_done_o", 1'b0, boot_done);
    check_bit("nbf_ready_o", 1'b0, nbf_ready);
    check_bit("host_cmd_ready_o", 1'b0, host_cmd_ready);
    check_bit("host_resp_v_o", 1'b0, host_resp_v);
    end_test("reset values");

    // host knocks during the config phase and must be ignored
    next_drive();
    host_cmd_v = 1'b1;
    repeat (gate_len_c - 2)
    begin
      @(negedge clk);
      check_bit("host_cmd_ready_o", 1'b0, host_cmd_ready);
    end
    next_drive();
    host_cmd_v = 1'b0;
    end_test("host gating");

    // freeze has to fall within the config budget
    wait_cnt = 0;
    @(negedge clk);
    while (freeze !== 1'b0 && wait_cnt < cfg_len_c)
    begin
      @(negedge clk);
      wait_cnt++;
    end
    check_bit("freeze_o", 1'b0, freeze);
    check_bit("boot_done_o", 1'b0, boot_done);
    next_drive();
    end_test("configuration phase");

    for (int i = 0; i < num_words_c; i++)
    begin
      gap  = $random(seed) & 3;
      word = $random(seed);
      words.push_back(word);
      repeat (gap) next_drive();
      send_word(word, i == num_words_c - 1);
    end
    @(negedge clk);
    while (!boot_done)
    begin
      @(negedge clk);
    end
    repeat (4)
    begin
      @(negedge clk);
      check_bit("boot_done_o", 1'b1, boot_done);
    end
    next_drive();
    end_test("program load");

    for (int i = 0; i < num_words_c; i++)
    begin
      host_read(boot_pkg::addr_t'(i), 0, rd);
      check_value($sformatf("host_data_o @%0d", i), words[i], rd);
    end
    // config space sits above the top address bit
    host_read(16'h8000, 0, rd);
    check_value("host_data_o @cfg0", '0, rd);
    for (int r = 1; r < boot_pkg::num_cfg_regs_c; r++)
    begin
      ri = boot_pkg::cfg_idx_t'(r);
      host_read(boot_pkg::addr_t'(16'h8000 + r), 0, rd);
      check_value($sformatf("host_data_o @cfg%0d", r), boot_pkg::cfg_table_c[ri], rd);
    end
    end_test("readback");

    for (int i = 0; i < num_words_c; i++)
    begin
      stall = 1 + ($random(seed) & 7);
      host_read(boot_pkg::addr_t'(i), stall, rd);
      check_value($sformatf("host_data_o @%0d", i), words[i], rd);
    end
    repeat (2) next_drive();
    end_test("back-pressure");

    $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, fail_total());
    if (fail_total() == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== boot_loader.f ====
hdl/boot_pkg.sv
hdl/cfg_loader.sv
hdl/nbf_loader.sv
hdl/load_arbiter.sv
hdl/boot_mem.sv
hdl/boot_loader.sv
test/boot_loader_checker.sv
test/tb_boot_loader.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, then run and search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_boot_loader -f boot_loader.f || exit 1
out=$(./obj_dir/Vtb_boot_loader +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
